/* all.f */
design/isa_pkg.sv
design/alu_pkg.sv
design/alu_shifter.sv
design/alu_execute.sv
design/alu_decode.sv
design/alu_result.sv
design/alu_exec_top.sv
test/alu_exec_assert.sv
test/alu_exec_tb.sv

/* Makefile */
# Verilator build and run for the RV64I execute path

VERILATOR ?= verilator
TOP       ?= alu_exec_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard design/*.sv test/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* test/alu_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_tb;
	import isa_pkg::*;
	import alu_pkg::*;

	localparam int xlen        = 64;
	localparam int num_instr   = 3000;
	localparam int drain_limit = 20; // cycles allowed for the pipeline to empty

	typedef struct packed {
		logic [31:0] instr;
		logic [63:0] result;
		alu_flags_t  flags;
		logic        illegal;
		logic [63:0] due;         // cycle count at which out_valid is expected
	} expect_t;

	logic            clk = 1'b0;
	logic            rst;
	logic            in_valid;
	logic [31:0]     instr;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic            out_valid;
	logic [xlen-1:0] result;
	alu_flags_t      flags;
	logic            illegal;

	int          seed    = 32764;
	int          sent    = 0;
	int          checked = 0;
	logic [63:0] cyc     = '0;
	expect_t     pending [$];
	expect_t     head;

	alu_exec_top #(.xlen(xlen)) dut0 (
		.clk, .rst, .in_valid, .instr, .rs1_val, .rs2_val,
		.out_valid, .result, .flags, .illegal
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 64'd1;

	task automatic stop_on_error();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	// reference model, straight from the RV64I rules
	function automatic expect_t model_exec(input logic [31:0] ins, input logic [63:0] a,
			input logic [63:0] rs2);
		expect_t     e;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic        alt;
		logic        word;
		logic        ill;
		logic        sub;
		logic        ovf;
		logic        less;
		logic [63:0] b;
		logic [64:0] wide;
		logic [63:0] sum;
		logic [5:0]  sh;
		logic [31:0] lo;
		logic [63:0] res;
		opc  = ins[6:0];
		f3   = ins[14:12];
		alt  = 1'b0;
		word = (opc == opc_op_32) || (opc == opc_op_imm_32);
		ill  = 1'b0;
		b    = rs2;
		case (opc)
			opc_op, opc_op_32: begin
				alt = (ins[31:25] == f7_alt);
				ill = (ins[31:25] != 7'd0) && !alt;
			end
			opc_op_imm, opc_op_imm_32: begin
				b   = {{52{ins[31]}}, ins[31:20]};
				alt = (f3 == f3_sr) && ins[30]; // srai, sraiw
			end
			opc_load: begin
				b  = {{52{ins[31]}}, ins[31:20]};
				f3 = f3_add;
			end
			opc_store: begin
				b  = {{52{ins[31]}}, ins[31:25], ins[11:7]};
				f3 = f3_add;
			end
			opc_branch: begin
				f3  = f3_add;
				alt = 1'b1; // rs1 minus rs2
			end
			default: begin
				ill = 1'b1;
				f3  = f3_add; // unknown opcode, adder adds
			end
		endcase
		if (word && !(f3 == f3_add || f3 == f3_sll || f3 == f3_sr))
			ill = 1'b1; // no logic or compare W ops
		sub  = (f3 == f3_add && alt) || f3 == f3_slt || f3 == f3_sltu;
		wide = {1'b0, a} + {1'b0, sub ? ~b : b} + {64'd0, sub};
		sum  = wide[63:0];
		ovf  = (a[63] == (b[63] ^ sub)) && (sum[63] != a[63]);
		less = (f3 == f3_sltu) ? (a < b) : (sum[63] ^ ovf); // signed less is N xor V
		sh   = word ? {1'b0, b[4:0]} : b[5:0];
		case (f3)
			f3_add:          res = sum;
			f3_sll:          res = a << sh;
			f3_slt, f3_sltu: res = {63'd0, less};
			f3_xor:          res = a ^ b;
			f3_or:           res = a | b;
			f3_and:          res = a & b;
			default: begin
				if (word) begin
					if (alt)
						lo = $signed(a[31:0]) >>> sh[4:0];
					else
						lo = a[31:0] >> sh[4:0];
					res = {32'd0, lo};
				end else if (alt) begin
					res = $signed(a) >>> sh;
				end else begin
					res = a >> sh;
				end
			end
		endcase
		if (word)
			res = {{32{res[31]}}, res[31:0]};
		if (ill)
			res = '0;
		e                = '0;
		e.instr          = ins;
		e.result         = res;
		e.flags.zero     = (sum == 64'd0);
		e.flags.carry    = wide[64];
		e.flags.less     = less;
		e.flags.overflow = ovf;
		e.illegal        = ill;
		return e;
	endfunction

	task automatic make_stimulus(output logic [31:0] ins, output logic [63:0] a,
			output logic [63:0] b);
		logic [31:0] r;
		logic [6:0]  opc;
		logic [6:0]  f7;
		r   = $random(seed);
		ins = $random(seed);
		a   = {$random(seed), $random(seed)};
		b   = {$random(seed), $random(seed)};
		if (r[9:8] == 2'd0)
			b = a; // equal operands, hits the zero flag
		f7 = r[4] ? f7_alt : 7'd0;
		case (r[3:0])
			4'd0, 4'd1, 4'd2, 4'd15: opc = opc_op;
			4'd3, 4'd4:              opc = opc_op_imm;
			4'd5, 4'd6:              opc = opc_op_32;
			4'd7, 4'd8:              opc = opc_op_imm_32;
			4'd9:                    opc = opc_load;
			4'd10:                   opc = opc_store;
			4'd11:                   opc = opc_branch;
			4'd12:                   opc = r[30:24]; // any opcode
			default: begin
				opc = r[3:0] == 4'd13 ? opc_op : opc_op_32;
				f7  = r[22:16]; // mostly bad funct7
			end
		endcase
		ins[6:0] = opc;
		if (opc == opc_op || opc == opc_op_32)
			ins[31:25] = f7;
	endtask

	// outputs sampled away from the driving edge
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			if (pending.size() == 0) begin
				$display("out_valid seen at %0t with no instruction in flight", $time);
				stop_on_error();
			end else begin
				head = pending.pop_front();
				check_equal($sformatf("latency of %h", head.instr), cyc, head.due);
				check_equal($sformatf("illegal of %h", head.instr), {63'd0, illegal},
					{63'd0, head.illegal});
				check_equal($sformatf("result of %h", head.instr), result, head.result);
				check_equal($sformatf("flags of %h", head.instr), {60'd0, flags},
					{60'd0, head.flags});
				checked++;
			end
		end
	end

	initial begin
		expect_t     e;
		logic [31:0] ins;
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] r;
		int          waited;
		rst      = 1'b1;
		in_valid = 1'b0;
		instr    = '0;
		rs1_val  = '0;
		rs2_val  = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		while (sent < num_instr) begin
			@(posedge clk);
			r = $random(seed);
			if (r[1:0] != 2'd0) begin // gaps between bursts of back-to-back strobes
				make_stimulus(ins, a, b);
				e     = model_exec(ins, a, b);
				e.due = cyc + 64'd3;
				pending.push_back(e);
				in_valid <= 1'b1;
				instr    <= ins;
				rs1_val  <= a;
				rs2_val  <= b;
				sent++;
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		waited = 0;
		while (pending.size() != 0 && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
		if (pending.size() == 0 && checked == sent) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("timeout: %0d of %0d instructions never produced out_valid",
				sent - checked, sent);
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

/* test/alu_exec_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_assert #(
	parameter int xlen = 64
) (
	input wire logic            clk,
	input wire logic            rst,
	input wire logic            in_valid,
	input wire logic            out_valid,
	input wire logic            illegal,
	input wire logic [xlen-1:0] result
);

	// fixed two-cycle pipeline, one out strobe per in strobe
	latency_a: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	reset_a: assert property (@(posedge clk)
		rst |=> (!out_valid && result == '0))
		else $error("outputs not cleared by reset");

	illegal_a: assert property (@(posedge clk)
		illegal |-> result == '0)
		else $error("illegal instruction with a nonzero result");

endmodule

bind alu_exec_top alu_exec_assert #(.xlen(xlen)) assert0 (
	.clk(clk), .rst(rst), .in_valid(in_valid), .out_valid(out_valid),
	.illegal(illegal), .result(result)
);

`default_nettype wire

/* design/alu_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top #(
	parameter int xlen = 64
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [31:0]         instr,
	input  logic [xlen-1:0]     rs1_val,
	input  logic [xlen-1:0]     rs2_val,
	output logic                out_valid,
	output logic [xlen-1:0]     result,
	output alu_pkg::alu_flags_t flags,
	output logic                illegal
);
	import alu_pkg::*;

	logic            dec_valid;
	alu_ctrl_t       dec_ctrl;
	logic [xlen-1:0] dec_a;
	logic [xlen-1:0] dec_b;

	logic            ex_valid;
	logic            ex_word;
	logic            ex_illegal;
	logic [xlen-1:0] ex_value;
	alu_flags_t      ex_flags;

	alu_decode #(.xlen(xlen)) decode0 (
		.clk, .rst, .in_valid, .instr, .rs1_val, .rs2_val,
		.dec_valid, .dec_ctrl, .dec_a, .dec_b
	);

	alu_execute #(.xlen(xlen)) execute0 ( // combinational
		.dec_valid, .dec_ctrl, .dec_a, .dec_b,
		.ex_valid, .ex_word, .ex_illegal, .ex_value, .ex_flags
	);

	alu_result #(.xlen(xlen)) result0 (
		.clk, .rst, .ex_valid, .ex_word, .ex_illegal, .ex_value, .ex_flags,
		.out_valid, .illegal, .result, .flags
	);

endmodule

`default_nettype wire

/* design/alu_result.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_result #(
	parameter int xlen = 64
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                ex_valid,
	input  logic                ex_word,
	input  logic                ex_illegal,
	input  logic [xlen-1:0]     ex_value,
	input  alu_pkg::alu_flags_t ex_flags,
	output logic                out_valid,
	output logic                illegal,
	output logic [xlen-1:0]     result,
	output alu_pkg::alu_flags_t flags
);
	logic [xlen-1:0] value_d;

	always_comb begin
		value_d = ex_value;
		if (ex_word) begin
			for (int i = 32; i < xlen; i++)
				value_d[i] = ex_value[31]; // W result sign extension
		end
		if (ex_illegal)
			value_d = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			illegal   <= 1'b0;
			result    <= '0;
			flags     <= '0;
		end else begin
			out_valid <= ex_valid; // one-cycle strobe
			if (ex_valid) begin
				illegal <= ex_illegal;
				result  <= value_d;
				flags   <= ex_flags;
			end
		end
	end

endmodule

`default_nettype wire

/* design/alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decode #(
	parameter int xlen = 64
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	input  logic [31:0]        instr,
	input  logic [xlen-1:0]    rs1_val,
	input  logic [xlen-1:0]    rs2_val,
	output logic               dec_valid,
	output alu_pkg::alu_ctrl_t dec_ctrl,
	output logic [xlen-1:0]    dec_a,
	output logic [xlen-1:0]    dec_b
);
	import isa_pkg::*;
	import alu_pkg::*;

	localparam bit has_w = (xlen == 64); // W opcodes exist on rv64 only

	instr_fields_t   f;
	alu_ctrl_t       ctrl_d;
	logic            alt;
	logic            bad_f7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] b_d;

	function automatic alu_op_e f3_op(input logic [2:0] funct3, input logic sel_alt);
		case (funct3)
			f3_add:  return sel_alt ? op_sub : op_add;
			f3_sll:  return op_sll;
			f3_slt:  return op_slt;
			f3_sltu: return op_sltu;
			f3_xor:  return op_xor;
			f3_sr:   return sel_alt ? op_sra : op_srl;
			f3_or:   return op_or;
			default: return op_and;
		endcase
	endfunction

	assign f      = instr;
	assign alt    = (f.funct7 == f7_alt);
	assign bad_f7 = (f.funct7 != 7'b0) && !alt;
	assign imm_i  = {{(xlen-12){instr[31]}}, instr[31:20]};
	assign imm_s  = {{(xlen-12){instr[31]}}, f.funct7, f.rd};

	always_comb begin
		ctrl_d    = '0;
		ctrl_d.op = op_add;
		case (f.opcode)
			opc_op: begin
				ctrl_d.op      = f3_op(f.funct3, alt);
				ctrl_d.illegal = bad_f7;
			end
			opc_op_32: begin
				ctrl_d.op      = f3_op(f.funct3, alt);
				ctrl_d.word    = 1'b1;
				ctrl_d.illegal = !has_w || bad_f7 || !(f.funct3 inside {f3_add, f3_sll, f3_sr});
			end
			opc_op_imm: begin
				ctrl_d.op      = f3_op(f.funct3, (f.funct3 == f3_sr) && instr[30]); // srai
				ctrl_d.use_imm = 1'b1;
			end
			opc_op_imm_32: begin
				ctrl_d.op      = f3_op(f.funct3, (f.funct3 == f3_sr) && instr[30]);
				ctrl_d.word    = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.illegal = !has_w || !(f.funct3 inside {f3_add, f3_sll, f3_sr});
			end
			opc_load, opc_store: ctrl_d.use_imm = 1'b1; // address add
			opc_branch: ctrl_d.op = op_sub; // flags only
			default: ctrl_d.illegal = 1'b1;
		endcase
	end

	always_comb begin
		b_d = rs2_val;
		if (ctrl_d.use_imm)
			b_d = (f.opcode == opc_store) ? imm_s : imm_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
			dec_ctrl  <= '0;
		end else begin
			dec_valid <= in_valid;
			if (in_valid)
				dec_ctrl <= ctrl_d;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			dec_a <= rs1_val;
			dec_b <= b_d;
		end
	end

endmodule

`default_nettype wire

/* design/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute #(
	parameter int xlen = 64
) (
	input  logic                dec_valid,
	input  alu_pkg::alu_ctrl_t  dec_ctrl,
	input  logic [xlen-1:0]     dec_a,
	input  logic [xlen-1:0]     dec_b,
	output logic                ex_valid,
	output logic                ex_word,
	output logic                ex_illegal,
	output logic [xlen-1:0]     ex_value,
	output alu_pkg::alu_flags_t ex_flags
);
	import alu_pkg::*;

	logic            sub;
	logic            carry;
	logic            arith;
	logic [xlen-1:0] b_eff;
	logic [xlen-1:0] sum;
	logic [xlen-1:0] shift_in;
	logic [xlen-1:0] shift_out;

	assign sub   = dec_ctrl.op inside {op_sub, op_slt, op_sltu}; // branch decodes to sub
	assign b_eff = dec_b ^ {xlen{sub}};
	assign {carry, sum} = {1'b0, dec_a} + {1'b0, b_eff} + {{xlen{1'b0}}, sub};

	assign ex_flags.zero     = ~|sum;
	assign ex_flags.carry    = carry;
	assign ex_flags.overflow = (dec_a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != dec_a[xlen-1]);
	assign ex_flags.less     = (dec_ctrl.op == op_sltu) ? ~carry // borrow out
	                                                    : ex_flags.overflow ^ sum[xlen-1];

	assign arith = (dec_ctrl.op == op_sra);

	// word right shifts see only the low word, extended per sraw/srlw
	always_comb begin
		shift_in = dec_a;
		if (dec_ctrl.word) begin
			for (int i = 32; i < xlen; i++)
				shift_in[i] = arith & dec_a[31];
		end
	end

	alu_shifter #(.xlen(xlen)) shifter0 (
		.din   (shift_in),
		.shamt (dec_b[5:0]),
		.word  (dec_ctrl.word),
		.left  (dec_ctrl.op == op_sll),
		.arith (arith),
		.dout  (shift_out)
	);

	always_comb begin
		case (dec_ctrl.op)
			op_and:                  ex_value = dec_a & dec_b;
			op_or:                   ex_value = dec_a | dec_b;
			op_xor:                  ex_value = dec_a ^ dec_b;
			op_slt, op_sltu:         ex_value = {{(xlen-1){1'b0}}, ex_flags.less};
			op_sll, op_srl, op_sra:  ex_value = shift_out;
			default:                 ex_value = sum; // add, sub
		endcase
	end

	assign ex_valid   = dec_valid;
	assign ex_word    = dec_ctrl.word;
	assign ex_illegal = dec_ctrl.illegal;

endmodule

`default_nettype wire

/* design/alu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter #(
	parameter int xlen = 64
) (
	input  logic [xlen-1:0] din,
	input  logic [5:0]      shamt,
	input  logic            word,
	input  logic            left,
	input  logic            arith,
	output logic [xlen-1:0] dout
);
	localparam int sw = $clog2(xlen);
	localparam logic [sw-1:0] word_mask = sw'(31); // 5-bit amount in word mode

	logic [sw-1:0]   amt;
	logic            fill;
	logic [xlen-1:0] stage [0:sw];

	function automatic logic [xlen-1:0] reverse(input logic [xlen-1:0] v);
		logic [xlen-1:0] r;
		for (int i = 0; i < xlen; i++)
			r[i] = v[xlen-1-i];
		return r;
	endfunction

	assign amt  = word ? (shamt[sw-1:0] & word_mask) : shamt[sw-1:0];
	assign fill = arith & ~left & din[xlen-1];

	// left shift = right shift on the bit-reversed word
	assign stage[0] = left ? reverse(din) : din;

	for (genvar k = 0; k < sw; k++) begin : g_stage
		assign stage[k+1] = amt[k] ? {{(1 << k){fill}}, stage[k][xlen-1:(1 << k)]}
		                           : stage[k];
	end

	assign dout = left ? reverse(stage[sw]) : stage[sw];

endmodule

`default_nettype wire

/* design/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_slt  = 4'd5,
		op_sltu = 4'd6,
		op_sll  = 4'd7,
		op_srl  = 4'd8,
		op_sra  = 4'd9
	} alu_op_e;

	// decoded control, registered with the operands
	typedef struct packed {
		alu_op_e op;
		logic    word;    // 32-bit op, result sign-extended
		logic    use_imm; // b operand is the immediate
		logic    illegal;
	} alu_ctrl_t;

	// condition flags, taken from the shared adder
	typedef struct packed {
		logic zero;
		logic carry;
		logic less;     // signed, or unsigned for sltu
		logic overflow;
	} alu_flags_t;

endpackage

`default_nettype wire

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// major opcodes, instr[6:0]
	localparam logic [6:0] opc_op        = 7'b0110011;
	localparam logic [6:0] opc_op_imm    = 7'b0010011;
	localparam logic [6:0] opc_op_32     = 7'b0111011; // rv64 only
	localparam logic [6:0] opc_op_imm_32 = 7'b0011011; // rv64 only
	localparam logic [6:0] opc_load      = 7'b0000011;
	localparam logic [6:0] opc_store     = 7'b0100011;
	localparam logic [6:0] opc_branch    = 7'b1100011;

	localparam logic [2:0] f3_add  = 3'b000; // also sub
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101; // srl or sra
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [6:0] f7_alt = 7'b0100000; // sub, sra

	// r-type layout, other formats reuse the same bit positions
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_fields_t;

endpackage

`default_nettype wire
